/* gfx_defs.svh */
`ifndef GFX_DEFS_SVH
`define GFX_DEFS_SVH

// Framebuffer geometry
`define GFX_FB_WIDTH  320
`define GFX_FB_HEIGHT 240

// Coordinate widths, enough for 0..319 and 0..239
`define GFX_X_W 9
`define GFX_Y_W 8

// Linear pixel address y*width + x, max 76799
`define GFX_ADDR_W 17

// 4:4:4 colour
`define GFX_COLOR_W 12

// clk_100m cycles per SRAM write slot
`define GFX_CE_DIV 2

// Written-pixel counter, wraps
`define GFX_CNT_W 16

`endif

/* gfx_cmd_pkg.sv */
`default_nettype none

`include "gfx_defs.svh"

package gfx_cmd_pkg;

    // Opcode sits in cmd_word[31:28]
    typedef enum logic [3:0] {
        OP_SET_COLOR  = 4'd1, // Colour in [11:0]
        OP_SET_ORIGIN = 4'd2, // x in [24:16], y in [7:0]
        OP_FILL_SPAN  = 4'd3  // Length in [8:0]
    } gfx_cmd_op_e;

    // Decoded operation from decode to execute
    // All fields filled from the word, execute picks per opcode
    typedef struct packed {
        gfx_cmd_op_e               opcode;
        logic [`GFX_COLOR_W-1:0]   color;
        logic [`GFX_X_W-1:0]       x;
        logic [`GFX_Y_W-1:0]       y;
        logic [`GFX_X_W-1:0]       len;   // 1..320 once accepted
    } gfx_op_t;

endpackage

`default_nettype wire

/* gfx_fb_pkg.sv */
`default_nettype none

`include "gfx_defs.svh"

package gfx_fb_pkg;

    // One framebuffer write
    typedef struct packed {
        logic [`GFX_ADDR_W-1:0]  addr;  // y*320 + x
        logic [`GFX_COLOR_W-1:0] color;
        logic                    last;  // Final pixel of span
    } gfx_pix_t;

endpackage

`default_nettype wire

/* gfx_strobe_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Strobe link with generic payload and busy return
interface gfx_strobe_if #(
    parameter type payload_t = logic
);

    logic     valid;   // One-cycle strobe
    payload_t payload; // Meaningful only with valid
    logic     busy;    // Sink still working

    modport source (
        output valid,
        output payload,
        input  busy
    );

    modport sink (
        input  valid,
        input  payload,
        output busy
    );

endinterface

`default_nettype wire

/* gfx_clocks.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gfx_defs.svh"

module gfx_clocks (
    input  logic clk_100m,
    input  logic arst_n_common, // Async, active low
    output logic rst_sync,      // Active high, released synchronously
    output logic wr_ce          // One cycle per write slot
);

    localparam int CNT_W = $clog2(`GFX_CE_DIV + 1);

    logic [1:0]       sync_q;   // Reset synchroniser chain
    logic [CNT_W-1:0] ce_cnt;

    // Assert at once, release on second edge
    always_ff @(posedge clk_100m or negedge arst_n_common) begin
        if (!arst_n_common) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    assign rst_sync = ~sync_q[1];

    // Slot pacing, SRAM rate inside clk_100m
    always_ff @(posedge clk_100m or posedge rst_sync) begin
        if (rst_sync) begin
            ce_cnt <= '0;
            wr_ce  <= 1'b0;
        end else begin
            wr_ce  <= (ce_cnt == CNT_W'(`GFX_CE_DIV - 1));
            ce_cnt <= (ce_cnt == CNT_W'(`GFX_CE_DIV - 1)) ? '0 : ce_cnt + 1'b1;
        end
    end

    // Slot spacing, one quiet cycle then the next slot GFX_CE_DIV cycles on
    a_ce_spacing : assert property (
        @(posedge clk_100m) disable iff (rst_sync)
        wr_ce |=> !wr_ce ##(`GFX_CE_DIV - 1) wr_ce)
        else $error("wr_ce slot spacing broken");

endmodule

`default_nettype wire

/* gfx_cmd_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gfx_defs.svh"

module gfx_cmd_decode (
    input  logic         clk_100m,
    input  logic         rst_sync,
    input  logic         cmd_valid, // One-cycle strobe
    input  logic [31:0]  cmd_word,
    output logic         cmd_err,   // Reject pulse
    output logic         busy,      // In flight or executing
    gfx_strobe_if.source op_bus
);

    logic [3:0]              op_code;
    logic [`GFX_COLOR_W-1:0] color;
    logic [`GFX_X_W-1:0]     org_x;
    logic [`GFX_Y_W-1:0]     org_y;
    logic [`GFX_X_W-1:0]     span_len;
    logic                    op_legal;
    logic                    accept;
    logic                    fill_inflight; // Registered fill not yet seen by execute
    gfx_cmd_pkg::gfx_op_t    op_next;

    // Field split
    assign op_code  = cmd_word[31:28];
    assign color    = cmd_word[11:0];
    assign org_x    = cmd_word[24:16];
    assign org_y    = cmd_word[7:0];
    assign span_len = cmd_word[8:0];

    // Opcode and range checks
    always_comb begin
        case (op_code)
            gfx_cmd_pkg::OP_SET_COLOR:  op_legal = 1'b1;
            gfx_cmd_pkg::OP_SET_ORIGIN: op_legal = (org_x < `GFX_FB_WIDTH) &&
                                                   (org_y < `GFX_FB_HEIGHT);
            gfx_cmd_pkg::OP_FILL_SPAN:  op_legal = (span_len != '0) &&
                                                   (span_len <= `GFX_FB_WIDTH);
            default:                    op_legal = 1'b0; // Unknown opcode
        endcase
    end

    assign busy   = fill_inflight | op_bus.busy;
    assign accept = cmd_valid & op_legal & ~busy; // Busy always rejects

    always_comb begin
        op_next        = '0;
        op_next.opcode = gfx_cmd_pkg::gfx_cmd_op_e'(op_code);
        op_next.color  = color;
        op_next.x      = org_x;
        op_next.y      = org_y;
        op_next.len    = span_len;
    end

    // Strobe, error and in-flight flags
    always_ff @(posedge clk_100m or posedge rst_sync) begin
        if (rst_sync) begin
            op_bus.valid  <= 1'b0;
            cmd_err       <= 1'b0;
            fill_inflight <= 1'b0;
        end else begin
            op_bus.valid  <= accept;
            cmd_err       <= cmd_valid & ~accept;
            fill_inflight <= accept && (op_code == gfx_cmd_pkg::OP_FILL_SPAN);
        end
    end

    // Payload, held between strobes
    always_ff @(posedge clk_100m) begin
        if (accept) begin
            op_bus.payload <= op_next;
        end
    end

endmodule

`default_nettype wire

/* gfx_span_exec.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gfx_defs.svh"

module gfx_span_exec (
    input  logic         clk_100m,
    input  logic         rst_sync,
    input  logic         wr_ce,   // Write slot
    gfx_strobe_if.sink   op_bus,
    gfx_strobe_if.source pix_bus
);

    localparam int ADDR_W = `GFX_ADDR_W;
    localparam logic [`GFX_X_W-1:0] FB_W = `GFX_X_W'(`GFX_FB_WIDTH);

    logic [`GFX_COLOR_W-1:0] color_q;
    logic [`GFX_X_W-1:0]     org_x_q;
    logic [`GFX_Y_W-1:0]     org_y_q;
    logic                    busy_q;
    logic [`GFX_X_W-1:0]     remain_q;  // Pixels left in span
    logic [ADDR_W-1:0]       addr_q;    // Next pixel address
    logic [`GFX_X_W-1:0]     room;      // Pixels up to right edge
    logic [`GFX_X_W-1:0]     span_len;  // Clipped length
    logic [ADDR_W-1:0]       span_base;
    logic                    take_fill;
    logic                    pix_fire;
    gfx_fb_pkg::gfx_pix_t    pix_w;

    assign room      = FB_W - org_x_q; // Origin x below 320, so at least 1
    assign span_len  = (op_bus.payload.len > room) ? room : op_bus.payload.len;
    assign span_base = ADDR_W'(org_y_q) * ADDR_W'(`GFX_FB_WIDTH) + ADDR_W'(org_x_q);
    assign take_fill = op_bus.valid && (op_bus.payload.opcode == gfx_cmd_pkg::OP_FILL_SPAN);
    assign pix_fire  = busy_q & wr_ce;

    // Colour, origin and span control
    always_ff @(posedge clk_100m or posedge rst_sync) begin
        if (rst_sync) begin
            color_q  <= '0;
            org_x_q  <= '0;
            org_y_q  <= '0;
            busy_q   <= 1'b0;
            remain_q <= '0;
        end else if (op_bus.valid) begin
            case (op_bus.payload.opcode)
                gfx_cmd_pkg::OP_SET_COLOR: color_q <= op_bus.payload.color;
                gfx_cmd_pkg::OP_SET_ORIGIN: begin
                    org_x_q <= op_bus.payload.x;
                    org_y_q <= op_bus.payload.y;
                end
                gfx_cmd_pkg::OP_FILL_SPAN: begin
                    busy_q   <= 1'b1;
                    remain_q <= span_len;
                end
                default: ; // Decode passes legal opcodes only
            endcase
        end else if (pix_fire) begin
            remain_q <= remain_q - 1'b1;
            if (remain_q == `GFX_X_W'(1)) begin
                busy_q <= 1'b0; // Last pixel out
            end
        end
    end

    // Address walker, origin itself stays put
    always_ff @(posedge clk_100m) begin
        if (take_fill) begin
            addr_q <= span_base;
        end else if (pix_fire) begin
            addr_q <= addr_q + 1'b1;
        end
    end

    always_comb begin
        pix_w.addr  = addr_q;
        pix_w.color = color_q; // Stable while busy
        pix_w.last  = (remain_q == `GFX_X_W'(1));
    end

    assign op_bus.busy     = busy_q;
    assign pix_bus.valid   = pix_fire;
    assign pix_bus.payload = pix_w;

    // Decode must hold off while a span runs
    a_no_op_while_busy : assert property (
        @(posedge clk_100m) disable iff (rst_sync) op_bus.valid |-> !busy_q)
        else $error("op_bus valid while span busy");

endmodule

`default_nettype wire

/* gfx_fb_result.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gfx_defs.svh"

module gfx_fb_result (
    input  logic                    clk_100m,
    input  logic                    rst_sync,
    gfx_strobe_if.sink              pix_bus,
    output logic                    fb_we,
    output logic [`GFX_ADDR_W-1:0]  fb_addr,
    output logic [`GFX_COLOR_W-1:0] fb_wdata,
    output logic                    span_done, // With last pixel
    output logic [`GFX_CNT_W-1:0]   pix_count  // Wraps at 2^16
);

    localparam int FB_PIXELS = `GFX_FB_WIDTH * `GFX_FB_HEIGHT;

    assign pix_bus.busy = 1'b0; // Always ready

    // Strobe, done and counter
    always_ff @(posedge clk_100m or posedge rst_sync) begin
        if (rst_sync) begin
            fb_we     <= 1'b0;
            span_done <= 1'b0;
            pix_count <= '0;
        end else begin
            fb_we     <= pix_bus.valid;
            span_done <= pix_bus.valid & pix_bus.payload.last;
            if (pix_bus.valid) begin
                pix_count <= pix_count + 1'b1; // Lines up with fb_we
            end
        end
    end

    // Write data path
    always_ff @(posedge clk_100m) begin
        if (pix_bus.valid) begin
            fb_addr  <= pix_bus.payload.addr;
            fb_wdata <= pix_bus.payload.color;
        end
    end

    // Clipping upstream keeps every write inside the frame
    a_addr_in_frame : assert property (
        @(posedge clk_100m) disable iff (rst_sync) fb_we |-> (fb_addr < FB_PIXELS))
        else $error("fb_addr %h outside framebuffer", fb_addr);

endmodule

`default_nettype wire

/* gfx_fill_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gfx_defs.svh"

module gfx_fill_top (
    input  logic                    clk_100m,
    input  logic                    arst_n_common,
    input  logic                    cmd_valid,
    input  logic [31:0]             cmd_word,
    output logic                    fb_we,
    output logic [`GFX_ADDR_W-1:0]  fb_addr,
    output logic [`GFX_COLOR_W-1:0] fb_wdata,
    output logic                    busy,
    output logic                    span_done,
    output logic                    cmd_err,
    output logic [`GFX_CNT_W-1:0]   pix_count
);

    logic rst_sync;
    logic wr_ce;

    gfx_strobe_if #(.payload_t(gfx_cmd_pkg::gfx_op_t)) op_bus ();  // Decode to execute
    gfx_strobe_if #(.payload_t(gfx_fb_pkg::gfx_pix_t)) pix_bus (); // Execute to result

    gfx_clocks u_gfx_clocks (
        .clk_100m      (clk_100m),
        .arst_n_common (arst_n_common),
        .rst_sync      (rst_sync),
        .wr_ce         (wr_ce)
    );

    gfx_cmd_decode u_gfx_cmd_decode (
        .clk_100m  (clk_100m),
        .rst_sync  (rst_sync),
        .cmd_valid (cmd_valid),
        .cmd_word  (cmd_word),
        .cmd_err   (cmd_err),
        .busy      (busy),      // In-flight OR execute busy
        .op_bus    (op_bus.source)
    );

    gfx_span_exec u_gfx_span_exec (
        .clk_100m (clk_100m),
        .rst_sync (rst_sync),
        .wr_ce    (wr_ce),
        .op_bus   (op_bus.sink),
        .pix_bus  (pix_bus.source)
    );

    gfx_fb_result u_gfx_fb_result (
        .clk_100m  (clk_100m),
        .rst_sync  (rst_sync),
        .pix_bus   (pix_bus.sink),
        .fb_we     (fb_we),
        .fb_addr   (fb_addr),
        .fb_wdata  (fb_wdata),
        .span_done (span_done),
        .pix_count (pix_count)
    );

endmodule

`default_nettype wire

/* tb_gfx_fill_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "gfx_defs.svh"

module tb_gfx_fill_top;

    localparam int N_ENTRIES = 17;
    localparam int N_RANDOM  = 6; // Random colour, origin, fill triples

    logic                    clk_100m;
    logic                    arst_n_common;
    logic                    cmd_valid;
    logic [31:0]             cmd_word;
    logic                    fb_we;
    logic [`GFX_ADDR_W-1:0]  fb_addr;
    logic [`GFX_COLOR_W-1:0] fb_wdata;
    logic                    busy;
    logic                    span_done;
    logic                    cmd_err;
    logic [`GFX_CNT_W-1:0]   pix_count;

    logic [31:0] tbl_word [N_ENTRIES];
    bit          tbl_rej  [N_ENTRIES]; // Expect cmd_err
    int          tbl_gap  [N_ENTRIES]; // Idle cycles after entry

    logic [`GFX_COLOR_W-1:0] m_color; // Model state
    logic [`GFX_X_W-1:0]     m_x;
    logic [`GFX_Y_W-1:0]     m_y;
    logic [29:0]             exp_q [$]; // {addr, colour, last}
    int errors;
    int total;      // Pixels the model expects
    int fills;      // Accepted fills
    int done_cnt;
    int cycle_cnt;
    int cycle_limit;

    gfx_fill_top u_gfx_fill_top (
        .clk_100m(clk_100m), .arst_n_common(arst_n_common),
        .cmd_valid(cmd_valid), .cmd_word(cmd_word),
        .fb_we(fb_we), .fb_addr(fb_addr), .fb_wdata(fb_wdata),
        .busy(busy), .span_done(span_done), .cmd_err(cmd_err), .pix_count(pix_count)
    );

    initial begin
        clk_100m = 1'b0;
        forever #5 clk_100m = ~clk_100m; // 100 MHz
    end

    function automatic logic [31:0] color_word(input logic [11:0] c);
        return {4'd1, 16'd0, c};
    endfunction

    function automatic logic [31:0] origin_word(input logic [8:0] x, input logic [7:0] y);
        return {4'd2, 3'd0, x, 8'd0, y};
    endfunction

    function automatic logic [31:0] fill_word(input logic [8:0] len);
        return {4'd3, 19'd0, len};
    endfunction

    task automatic set_entry(input int i, input logic [31:0] w, input bit r, input int g);
        tbl_word[i] = w;
        tbl_rej[i]  = r;
        tbl_gap[i]  = g;
    endtask

    task automatic load_table();
        set_entry(0,  fill_word(9'd4),            1'b0, 1); // Reset colour, address 0
        set_entry(1,  color_word(12'hA5C),        1'b0, 0);
        set_entry(2,  origin_word(9'd10, 8'd3),   1'b0, 0);
        set_entry(3,  fill_word(9'd5),            1'b0, 0);
        set_entry(4,  color_word(12'h0F0),        1'b1, 0); // Lands in busy window
        set_entry(5,  origin_word(9'd316, 8'd10), 1'b0, 0);
        set_entry(6,  32'hF000_0000,              1'b1, 1); // Illegal opcode
        set_entry(7,  origin_word(9'd320, 8'd0),  1'b1, 0);
        set_entry(8,  origin_word(9'd0, 8'd240),  1'b1, 0);
        set_entry(9,  fill_word(9'd0),            1'b1, 0);
        set_entry(10, fill_word(9'd321),          1'b1, 2);
        set_entry(11, fill_word(9'd10),           1'b0, 0); // Clipped to 4
        set_entry(12, color_word(12'h123),        1'b0, 0);
        set_entry(13, origin_word(9'd0, 8'd239),  1'b0, 0);
        set_entry(14, fill_word(9'd320),          1'b0, 3); // Full row
        set_entry(15, fill_word(9'd2),            1'b1, 0); // Still busy
        set_entry(16, fill_word(9'd1),            1'b0, 0);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_100m);
            #1;
        end
    endtask

    task automatic wait_idle();
        while (busy) begin
            @(posedge clk_100m);
            #1;
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Reference rules, pixels queued in write order
    task automatic model_update(input logic [31:0] w);
        int               n;
        int               room;
        logic [16:0]      base;
        case (w[31:28])
            4'd1: m_color = w[11:0];
            4'd2: begin
                m_x = w[24:16];
                m_y = w[7:0];
            end
            4'd3: begin
                n    = w[8:0];
                room = `GFX_FB_WIDTH - m_x; // Clip at right edge
                if (n > room) n = room;
                base = m_y * `GFX_FB_WIDTH + m_x;
                for (int i = 0; i < n; i++) begin
                    exp_q.push_back({base + 17'(i), m_color, (i == n - 1)});
                end
                total += n;
                fills++;
            end
            default: ;
        endcase
    endtask

    // One-cycle strobe, cmd_err due one cycle later
    task automatic apply_cmd(input logic [31:0] w, input bit rej);
        cmd_word  = w;
        cmd_valid = 1'b1;
        @(posedge clk_100m);
        #1;
        cmd_valid = 1'b0;
        compare_value("cmd_err", cmd_err, rej);
        if (!rej) model_update(w);
    endtask

    // Outputs settle by the falling edge
    always @(negedge clk_100m) begin
        if (span_done === 1'b1) done_cnt++;
        if (fb_we === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Write to address %h arrived with no pixel expected", fb_addr);
            end else begin
                compare_value("fb_addr", fb_addr, exp_q[0][29:13]);
                compare_value("fb_wdata", fb_wdata, exp_q[0][12:1]);
                compare_value("span_done", span_done, exp_q[0][0]); // High on final pixel only
                void'(exp_q.pop_front());
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        @(posedge clk_100m);
        while (cycle_cnt < cycle_limit) begin
            @(posedge clk_100m);
            cycle_cnt++;
        end
        $display("Run stopped by timeout after %0d cycles", cycle_cnt);
        $display("Checks failed");
        $finish;
    end

    initial begin
        arst_n_common = 1'b0;
        cmd_valid     = 1'b0;
        cmd_word      = '0;
        m_color       = '0;
        m_x           = '0;
        m_y           = '0;
        errors        = 0;
        total         = 0;
        fills         = 0;
        done_cnt      = 0;
        void'($urandom(32'h66b7_d9ee));
        load_table();
        // Gaps, command overhead and worst-case span time
        cycle_limit = 500 + (3 * N_RANDOM) * 8 + `GFX_CE_DIV * N_RANDOM * `GFX_FB_WIDTH;
        for (int i = 0; i < N_ENTRIES; i++) begin
            cycle_limit += tbl_gap[i] + 8;
            if (!tbl_rej[i] && tbl_word[i][31:28] == 4'd3)
                cycle_limit += `GFX_CE_DIV * tbl_word[i][8:0];
        end
        repeat (3) @(posedge clk_100m);
        #1;
        arst_n_common = 1'b1;
        idle_cycles(4); // Synchroniser release
        compare_value("fb_we", fb_we, 1'b0);
        compare_value("busy", busy, 1'b0);
        compare_value("span_done", span_done, 1'b0);
        compare_value("cmd_err", cmd_err, 1'b0);
        compare_value("pix_count", pix_count, '0);
        // Rejects right after a fill hit the busy window, all others start idle
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (!((i > 0) && tbl_rej[i] && tbl_word[i-1][31:28] == 4'd3)) wait_idle();
            apply_cmd(tbl_word[i], tbl_rej[i]);
            idle_cycles(tbl_gap[i]);
        end
        for (int r = 0; r < N_RANDOM; r++) begin
            wait_idle();
            apply_cmd(color_word(12'($urandom)), 1'b0);
            apply_cmd(origin_word(9'($urandom % 320), 8'($urandom % 240)), 1'b0);
            apply_cmd(fill_word(9'(1 + $urandom % 320)), 1'b0);
        end
        wait_idle();
        idle_cycles(4); // Drain result stage
        compare_value("pix_count", pix_count, total[15:0]);
        compare_value("span_done count", done_cnt, fills);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected pixels were never written", exp_q.size());
        end
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* gfx_fill_top.f */
+incdir+.
gfx_cmd_pkg.sv
gfx_fb_pkg.sv
gfx_strobe_if.sv
gfx_clocks.sv
gfx_cmd_decode.sv
gfx_span_exec.sv
gfx_fb_result.sv
gfx_fill_top.sv
tb_gfx_fill_top.sv

/* Bender.yml */
package:
  name: gfx_fill

sources:
  - include_dirs:
      - .
    files:
      - gfx_cmd_pkg.sv
      - gfx_fb_pkg.sv
      - gfx_strobe_if.sv
      - gfx_clocks.sv
      - gfx_cmd_decode.sv
      - gfx_span_exec.sv
      - gfx_fb_result.sv
      - gfx_fill_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_gfx_fill_top.sv
